/* common/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define XLEN        64
`define ILEN        32
`define REG_ADDR_W  5
`define OPCODE_W    7
`define F3_W        3
`define F7_W        7
`define ILL_CNT_W   16

`define OP_REG      7'b0110011 // add, sub
`define OP_IMM      7'b0010011 // addi, sltiu
`define OP_REG_W    7'b0111011 // addw
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_BRANCH   7'b1100011
`define OP_SYSTEM   7'b1110011

`define F3_ADD_SUB  3'b000
`define F3_ADDI     3'b000
`define F3_SLTIU    3'b011
`define F3_ADDW     3'b000
`define F3_LW       3'b010
`define F3_SD       3'b011
`define F3_JALR     3'b000
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

`define F7_BASE     7'b0000000
`define F7_SUB      7'b0100000

`define EBREAK_WORD 32'h0010_0073

`endif

/* common/decode_pkg.sv */
`include "decode_config.svh"

package decode_pkg;

    typedef struct packed {
        logic [`F7_W-1:0]       funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm_11_0;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [4:0]             imm_4_0;
        logic [`OPCODE_W-1:0]   opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`F3_W-1:0]       funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [`OPCODE_W-1:0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } j_fmt_t;

    // one word read in six layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_subn = 4'd2, // zero flag inverted for beq
        alu_sltu = 4'd3,
        alu_and  = 4'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        src_reg     = 2'd0,
        src_imm     = 2'd1,
        src_pc_imm  = 2'd2,
        src_four_pc = 2'd3 // link value pc + 4
    } alu_src_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_e;

    typedef enum logic [1:0] {
        ext_none      = 2'd0,
        ext_load_word = 2'd1,
        ext_word_sign = 2'd2, // sign-extend low 32 bits
        ext_jalr_mask = 2'd3  // clear bit 0 of target
    } ext_e;

    typedef struct packed {
        logic                   reg_wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        alu_op_e                alu_op;
        alu_src_e               alu_src;
        imm_sel_e               imm_sel;
        ext_e                   ext;
        logic                   branch;
        logic                   jump;
        logic                   jalr;
        logic                   load;
        logic                   store;
        logic [7:0]             wmask;
        logic                   ebreak;
        logic                   illegal;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] i;
        logic [`XLEN-1:0] s;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] u;
        logic [`XLEN-1:0] j;
    } imm_set_t;

    typedef struct packed {
        logic                   reg_wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        alu_op_e                alu_op;
        alu_src_e               alu_src;
        ext_e                   ext;
        logic                   branch;
        logic                   jump;
        logic                   jalr;
        logic                   load;
        logic                   store;
        logic [7:0]             wmask;
        logic                   ebreak;
        logic                   illegal;
        logic [`XLEN-1:0]       imm;
        logic [`ILEN-1:0]       inst;
    } decoded_t;

endpackage

/* decode/inst_ctrl.sv */
`timescale 1ns/1ns

`include "decode_config.svh"

module inst_ctrl (
    input  decode_pkg::inst_u inst,
    output decode_pkg::ctrl_t ctrl
);

    import decode_pkg::*;

    logic [`OPCODE_W-1:0] opcode;
    logic [`F3_W-1:0]     funct3;
    logic [`F7_W-1:0]     funct7;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;

    always_comb begin
        ctrl.reg_wen = 1'b0;
        ctrl.rd      = '0;
        ctrl.rs1     = '0;
        ctrl.rs2     = '0;
        ctrl.alu_op  = alu_and;
        ctrl.alu_src = src_reg;
        ctrl.imm_sel = imm_i;
        ctrl.ext     = ext_none;
        ctrl.branch  = 1'b0;
        ctrl.jump    = 1'b0;
        ctrl.jalr    = 1'b0;
        ctrl.load    = 1'b0;
        ctrl.store   = 1'b0;
        ctrl.wmask   = 8'h00;
        ctrl.ebreak  = 1'b0;
        ctrl.illegal = 1'b0;
        case (opcode)
            `OP_REG: begin
                if (funct3 == `F3_ADD_SUB &&
                        (funct7 == `F7_BASE || funct7 == `F7_SUB)) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = inst.r.rd;
                    ctrl.rs1     = inst.r.rs1;
                    ctrl.rs2     = inst.r.rs2;
                    ctrl.alu_op  = (funct7 == `F7_SUB) ? alu_sub : alu_add;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            `OP_IMM: begin
                case (funct3)
                    `F3_ADDI, `F3_SLTIU: begin
                        ctrl.reg_wen = 1'b1;
                        ctrl.rd      = inst.i.rd;
                        ctrl.rs1     = inst.i.rs1;
                        ctrl.alu_src = src_imm;
                        ctrl.alu_op  = (funct3 == `F3_SLTIU) ? alu_sltu : alu_add;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `OP_REG_W: begin
                if (funct3 == `F3_ADDW && funct7 == `F7_BASE) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = inst.r.rd;
                    ctrl.rs1     = inst.r.rs1;
                    ctrl.rs2     = inst.r.rs2;
                    ctrl.alu_op  = alu_add;
                    ctrl.ext     = ext_word_sign; // result truncated to 32 bits
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            `OP_LOAD: begin
                if (funct3 == `F3_LW) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = inst.i.rd;
                    ctrl.rs1     = inst.i.rs1;
                    ctrl.alu_op  = alu_add;
                    ctrl.alu_src = src_imm; // address rs1 + imm
                    ctrl.load    = 1'b1;
                    ctrl.ext     = ext_load_word;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            `OP_STORE: begin
                if (funct3 == `F3_SD) begin
                    ctrl.rs1     = inst.s.rs1;
                    ctrl.rs2     = inst.s.rs2;
                    ctrl.alu_op  = alu_add;
                    ctrl.alu_src = src_imm;
                    ctrl.imm_sel = imm_s;
                    ctrl.store   = 1'b1;
                    ctrl.wmask   = 8'hff; // full doubleword
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            `OP_JAL: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.j.rd;
                ctrl.jump    = 1'b1;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_four_pc;
                ctrl.imm_sel = imm_j;
            end
            `OP_JALR: begin
                if (funct3 == `F3_JALR) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.rd      = inst.i.rd;
                    ctrl.rs1     = inst.i.rs1;
                    ctrl.jump    = 1'b1;
                    ctrl.jalr    = 1'b1;
                    ctrl.alu_op  = alu_add;
                    ctrl.alu_src = src_four_pc;
                    ctrl.ext     = ext_jalr_mask;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            `OP_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.u.rd;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_imm; // x0 + imm
                ctrl.imm_sel = imm_u;
            end
            `OP_AUIPC: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.u.rd;
                ctrl.alu_op  = alu_add;
                ctrl.alu_src = src_pc_imm;
                ctrl.imm_sel = imm_u;
            end
            `OP_BRANCH: begin
                case (funct3)
                    `F3_BEQ, `F3_BNE: begin
                        ctrl.rs1     = inst.b.rs1;
                        ctrl.rs2     = inst.b.rs2;
                        ctrl.branch  = 1'b1;
                        ctrl.imm_sel = imm_b;
                        ctrl.alu_op  = (funct3 == `F3_BEQ) ? alu_subn : alu_sub;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `OP_SYSTEM: begin
                if (inst == `EBREAK_WORD) ctrl.ebreak = 1'b1;
                else ctrl.illegal = 1'b1; // ecall, csr ops not decoded
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

    always_comb begin
        assert (!(ctrl.illegal &&
                  (ctrl.reg_wen || ctrl.store || ctrl.branch || ctrl.jump)))
            else $error("illegal word decoded with an enable set");
        assert (!(ctrl.branch && ctrl.jump))
            else $error("branch and jump both set");
    end

endmodule

/* decode/imm_gen.sv */
`timescale 1ns/1ns

`include "decode_config.svh"

module imm_gen (
    input  decode_pkg::inst_u    inst,
    output decode_pkg::imm_set_t imms
);

    logic sign;

    assign sign = inst.i.imm_11_0[11]; // bit 31 in every format

    assign imms.i = {{(`XLEN-12){sign}}, inst.i.imm_11_0};

    assign imms.s = {
        {(`XLEN-12){sign}},
        inst.s.imm_11_5,
        inst.s.imm_4_0
    };

    // bit 0 always zero
    assign imms.b = {
        {(`XLEN-13){sign}},
        inst.b.imm_12,
        inst.b.imm_11,
        inst.b.imm_10_5,
        inst.b.imm_4_1,
        1'b0
    };

    assign imms.u = {
        {(`XLEN-32){sign}},
        inst.u.imm_31_12,
        12'h000
    };

    assign imms.j = {
        {(`XLEN-21){sign}},
        inst.j.imm_20,
        inst.j.imm_19_12,
        inst.j.imm_11,
        inst.j.imm_10_1,
        1'b0
    };

endmodule

/* logic/decode_merge.sv */
`timescale 1ns/1ns

`include "decode_config.svh"

module decode_merge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    input  decode_pkg::inst_u      inst,
    input  decode_pkg::ctrl_t      ctrl,
    input  decode_pkg::imm_set_t   imms,
    output logic                   dec_valid,
    output decode_pkg::decoded_t   dec,
    output logic [`ILL_CNT_W-1:0]  illegal_count
);

    import decode_pkg::*;

    logic [`XLEN-1:0] imm_pick;
    logic             wen_eff;
    decoded_t         dec_next;

    always_comb begin
        case (ctrl.imm_sel)
            imm_s:   imm_pick = imms.s;
            imm_b:   imm_pick = imms.b;
            imm_u:   imm_pick = imms.u;
            imm_j:   imm_pick = imms.j;
            default: imm_pick = imms.i;
        endcase
    end

    // writes to x0 are dropped here
    assign wen_eff = ctrl.reg_wen && (ctrl.rd != '0) && !ctrl.illegal;

    always_comb begin
        dec_next.reg_wen = wen_eff;
        dec_next.rd      = ctrl.rd;
        dec_next.rs1     = ctrl.rs1;
        dec_next.rs2     = ctrl.rs2;
        dec_next.alu_op  = ctrl.alu_op;
        dec_next.alu_src = ctrl.alu_src;
        dec_next.ext     = ctrl.ext;
        dec_next.branch  = ctrl.branch;
        dec_next.jump    = ctrl.jump;
        dec_next.jalr    = ctrl.jalr;
        dec_next.load    = ctrl.load;
        dec_next.store   = ctrl.store;
        dec_next.wmask   = ctrl.wmask;
        dec_next.ebreak  = ctrl.ebreak;
        dec_next.illegal = ctrl.illegal;
        dec_next.imm     = imm_pick;
        dec_next.inst    = inst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid     <= 1'b0;
            dec           <= '0;
            illegal_count <= '0;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                dec <= dec_next;
                if (ctrl.illegal && illegal_count != '1) begin
                    illegal_count <= illegal_count + 1'b1; // saturates
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) dec_valid |-> $past(inst_valid))
        else $error("output strobe without input strobe");

    assert property (@(posedge clk) disable iff (rst)
            !$past(rst) |-> illegal_count >= $past(illegal_count))
        else $error("illegal count went down");

endmodule

/* logic/decode_top.sv */
`timescale 1ns/1ns

`include "decode_config.svh"

module decode_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  logic [`ILEN-1:0]      inst,
    output logic                  dec_valid,
    output decode_pkg::decoded_t  dec,
    output logic [`ILL_CNT_W-1:0] illegal_count
);

    import decode_pkg::*;

    inst_u    inst_view;
    ctrl_t    ctrl;
    imm_set_t imms;

    assign inst_view = inst_u'(inst);

    inst_ctrl u_inst_ctrl (
        .inst (inst_view),
        .ctrl (ctrl)
    );

    imm_gen u_imm_gen (
        .inst (inst_view),
        .imms (imms)
    );

    decode_merge u_decode_merge (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst_view),
        .ctrl          (ctrl),
        .imms          (imms),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .illegal_count (illegal_count)
    );

endmodule

/* test/decode_tb.sv */
`timescale 1ns/1ns

`include "decode_config.svh"

module decode_tb;

    import decode_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  inst_valid;
    logic [`ILEN-1:0]      inst;
    logic                  dec_valid;
    decoded_t              dec;
    logic [`ILL_CNT_W-1:0] illegal_count;

    decoded_t exp_q[$];
    int       gap_q[$];
    int       issue_q[$];
    int       cycle = 0;
    logic     valid_d = 1'b0;
    int       errors;
    int       n_pass;
    int       n_fail;
    int       ill_exp;
    logic     monitor_on;
    logic     test_bad;
    logic     timed_out;

    decode_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .dec_valid     (dec_valid),
        .dec           (dec),
        .illegal_count (illegal_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle   <= cycle + 1;
        valid_d <= inst_valid; // strobe taken at this edge
    end

    // output strobe must track the input strobe one cycle later
    always @(negedge clk) begin
        if (monitor_on) begin
            assert (dec_valid === valid_d)
            else begin
                $display("error at %0t ns: dec_valid expected %0b, got %0b",
                         $time, valid_d, dec_valid);
                errors++;
            end
        end
    end

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual)
        else begin
            $display("error at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic load_stimulus();
        int                fd;
        int                n;
        int                lines;
        logic [8*256-1:0]  line;
        logic [63:0]       f [17];
        decoded_t          e;
        fd = $fopen("test/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < 1000) begin
                lines++;
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                    if (n == 17) begin
                        e         = '0;
                        e.inst    = f[0][31:0];
                        e.reg_wen = f[1][0];
                        e.rd      = f[2][4:0];
                        e.rs1     = f[3][4:0];
                        e.rs2     = f[4][4:0];
                        e.alu_op  = alu_op_e'(f[5][3:0]);
                        e.alu_src = alu_src_e'(f[6][1:0]);
                        e.imm     = f[7];
                        e.branch  = f[8][0];
                        e.jump    = f[9][0];
                        e.jalr    = f[10][0];
                        e.load    = f[11][0];
                        e.store   = f[12][0];
                        e.wmask   = f[13][7:0];
                        e.ext     = ext_e'(f[14][1:0]);
                        e.ebreak  = f[15][0];
                        e.illegal = f[16][0];
                        exp_q.push_back(e);
                    end else if (n > 0) begin
                        $display("stimulus line %0d has %0d of 17 columns", lines, n);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_all();
        for (int i = 0; i < exp_q.size(); i++) begin
            repeat (gap_q[i]) begin
                @(posedge clk);
                inst_valid <= 1'b0;
                inst       <= '0;
            end
            @(posedge clk);
            inst_valid <= 1'b1;
            inst       <= exp_q[i].inst;
            issue_q.push_back(cycle);
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= '0;
    endtask

    task automatic compare_item(input int k, input decoded_t e, input int latency);
        test_bad = 1'b0;
        if (e.illegal) ill_exp++;
        check_field("dec_valid latency", 1, latency);
        check_field("reg_wen", e.reg_wen, dec.reg_wen);
        check_field("rd", e.rd, dec.rd);
        check_field("rs1", e.rs1, dec.rs1);
        check_field("rs2", e.rs2, dec.rs2);
        check_field("alu_op", e.alu_op, dec.alu_op);
        check_field("alu_src", e.alu_src, dec.alu_src);
        check_field("imm", e.imm, dec.imm);
        check_field("branch", e.branch, dec.branch);
        check_field("jump", e.jump, dec.jump);
        check_field("jalr", e.jalr, dec.jalr);
        check_field("load", e.load, dec.load);
        check_field("store", e.store, dec.store);
        check_field("wmask", e.wmask, dec.wmask);
        check_field("ext", e.ext, dec.ext);
        check_field("ebreak", e.ebreak, dec.ebreak);
        check_field("illegal", e.illegal, dec.illegal);
        check_field("inst", e.inst, dec.inst);
        check_field("illegal_count", ill_exp, illegal_count);
        if (test_bad) begin
            n_fail++;
            $display("test %0d failed: inst %h", k, e.inst);
        end else begin
            n_pass++;
            $display("test %0d passed: inst %h", k, e.inst);
        end
    endtask

    task automatic check_all();
        int   waited;
        int   issued;
        logic seen;
        for (int k = 0; k < exp_q.size() && !timed_out; k++) begin
            waited = 0;
            while (issue_q.size() == 0 && waited < 10) begin
                @(negedge clk);
                waited++;
            end
            if (issue_q.size() == 0) begin
                $display("no input strobe was driven for test %0d", k);
                n_fail++;
                timed_out = 1'b1;
            end else begin
                issued = issue_q.pop_front();
                waited = 0;
                seen   = 1'b0;
                while (!seen && waited < 10) begin
                    @(negedge clk);
                    waited++;
                    seen = dec_valid;
                end
                if (!seen) begin
                    $display("no output strobe for test %0d", k);
                    n_fail++;
                    timed_out = 1'b1;
                end else begin
                    compare_item(k, exp_q[k], cycle - issued - 1);
                end
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        errors     = 0;
        n_pass     = 0;
        n_fail     = 0;
        ill_exp    = 0;
        monitor_on = 1'b0;
        test_bad   = 1'b0;
        timed_out  = 1'b0;
        void'($urandom(64089));
        load_stimulus();
        for (int i = 0; i < exp_q.size(); i++) begin
            gap_q.push_back($urandom % 4); // idle cycles before each strobe
        end

        @(posedge clk);
        @(negedge clk);
        check_field("dec_valid", 0, dec_valid); // still in reset
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_field("dec_valid", 0, dec_valid);
        check_field("illegal_count", 0, illegal_count);
        assert (dec === '0)
        else begin
            $display("error at %0t ns: dec expected 0, got %h", $time, dec);
            errors++;
            test_bad = 1'b1;
        end
        if (test_bad) $display("reset test failed");
        else $display("reset test passed");

        monitor_on = 1'b1;
        fork
            drive_all();
            check_all();
        join

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 exp_q.size(), n_pass, n_fail, errors);
        if (errors == 0 && !timed_out && n_fail == 0 && exp_q.size() > 0 &&
                n_pass == exp_q.size()) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/decode_pkg.sv
decode/inst_ctrl.sv
decode/imm_gen.sv
logic/decode_merge.sv
logic/decode_top.sv
test/decode_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ns \
    --top-module decode_tb \
    -f files.f \
    -o decode_sim

./obj_dir/decode_sim 2>&1 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* test/decode_stimulus.txt */
# inst reg_wen rd rs1 rs2 alu_op alu_src imm branch jump jalr load store wmask ext ebreak illegal
# all hex; alu_op add=0 sub=1 subn=2 sltu=3 and=4; alu_src reg=0 imm=1 pc_imm=2 four_pc=3
# ext none=0 load_word=1 word_sign=2 jalr_mask=3
002081b3 1 03 01 02 0 0 0000000000000002 0 0 0 0 0 00 0 0 0
407302b3 1 05 06 07 1 0 0000000000000407 0 0 0 0 0 00 0 0 0
00208033 0 00 01 02 0 0 0000000000000002 0 0 0 0 0 00 0 0 0
fff58513 1 0a 0b 00 0 1 ffffffffffffffff 0 0 0 0 0 00 0 0 0
0646b613 1 0c 0d 00 3 1 0000000000000064 0 0 0 0 0 00 0 0 0
0107873b 1 0e 0f 10 0 0 0000000000000010 0 0 0 0 0 00 2 0 0
00000013 0 00 00 00 0 1 0000000000000000 0 0 0 0 0 00 0 0 0
ffc12403 1 08 02 00 0 1 fffffffffffffffc 0 0 0 1 0 00 1 0 0
0101a483 1 09 03 00 0 1 0000000000000010 0 0 0 1 0 00 1 0 0
00513423 0 00 02 05 0 1 0000000000000008 0 0 0 0 1 ff 0 0 0
fe643823 0 00 08 06 0 1 fffffffffffffff0 0 0 0 0 1 ff 0 0 0
123453b7 1 07 00 00 0 1 0000000012345000 0 0 0 0 0 00 0 0 0
fffff0b7 1 01 00 00 0 1 fffffffffffff000 0 0 0 0 0 00 0 0 0
80000217 1 04 00 00 0 2 ffffffff80000000 0 0 0 0 0 00 0 0 0
00208463 0 00 01 02 2 0 0000000000000008 1 0 0 0 0 00 0 0 0
fe419ee3 0 00 03 04 1 0 fffffffffffffffc 1 0 0 0 0 00 0 0 0
001000ef 1 01 00 00 0 3 0000000000000800 0 1 0 0 0 00 0 0 0
ff9ff06f 0 00 00 00 0 3 fffffffffffffff8 0 1 0 0 0 00 0 0 0
00c280e7 1 01 05 00 0 3 000000000000000c 0 1 1 0 0 00 3 0 0
00008067 0 00 01 00 0 3 0000000000000000 0 1 1 0 0 00 3 0 0
00100073 0 00 00 00 4 0 0000000000000001 0 0 0 0 0 00 0 1 0
00000073 0 00 00 00 4 0 0000000000000000 0 0 0 0 0 00 0 0 1
ffffffff 0 00 00 00 4 0 ffffffffffffffff 0 0 0 0 0 00 0 0 1
00109093 0 00 00 00 4 0 0000000000000001 0 0 0 0 0 00 0 0 1
00013083 0 00 00 00 4 0 0000000000000000 0 0 0 0 0 00 0 0 1
0020c463 0 00 00 00 4 0 0000000000000002 0 0 0 0 0 00 0 0 1
023100b3 0 00 00 00 4 0 0000000000000023 0 0 0 0 0 00 0 0 1
7ff00f93 1 1f 00 00 0 1 00000000000007ff 0 0 0 0 0 00 0 0 0
